// File: opq_pkg.sv
//////////////////////////////////////////////////
// Operand queue package
// Widths, queue indices, conversion codes and
// default depths shared by the queue stage
//////////////////////////////////////////////////

package opq_pkg;

  // Element geometry
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned HalfWidth = 32;

  ////////////////////////////////////////////////
  // Queue indices
  ////////////////////////////////////////////////

  localparam int unsigned NrQueues = 5;
  localparam int unsigned AluA     = 0;
  localparam int unsigned AluB     = 1;
  localparam int unsigned StA      = 2;
  localparam int unsigned PermIdx  = 3;
  localparam int unsigned PermVal  = 4;

  // Conversion applied on the way to the unit
  localparam logic [1:0] ConvNone  = 2'd0;
  localparam logic [1:0] ConvZext2 = 2'd1;
  localparam logic [1:0] ConvSext2 = 2'd2;

  // Output words per command
  localparam int unsigned CmdLenWidth = 8;

  ////////////////////////////////////////////////
  // Default depths
  ////////////////////////////////////////////////

  localparam int unsigned ValuDataDepth = 5;
  localparam int unsigned StuDataDepth  = 2;
  localparam int unsigned PermDataDepth = 2;
  localparam int unsigned CmdDepth      = 4;

  // One register file word, whole or as halves (half[0] is the low one)
  typedef union packed {
    logic [ElenWidth-1:0]      elem;
    logic [1:0][HalfWidth-1:0] half;
  } opq_word_u;

endpackage

// File: opq_data_if.sv
//////////////////////////////////////////////////
// Buffer to converter link
// Head word, its valid, the pop and the flush
//////////////////////////////////////////////////

interface opq_data_if;

  import opq_pkg::*;

  opq_word_u word;
  logic      valid;
  logic      pop;
  logic      flush;

  modport buf_mp (output word, output valid, output flush, input pop);

  modport conv_mp (input word, input valid, input flush, output pop);

endinterface

// File: opq_buffer.sv
//////////////////////////////////////////////////
// Operand buffer
// Circular data FIFO of one queue with credit flow
// control towards the operand requester and an
// optional registered flush
//////////////////////////////////////////////////

module opq_buffer #(
  parameter int unsigned DataBufDepth = opq_pkg::ValuDataDepth,
  parameter bit          HasFlush     = 1'b0
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               flush_i,
  input  opq_pkg::opq_word_u operand_i,
  input  logic               operand_valid_i,
  input  logic               operand_issued_i,
  output logic               operand_queue_ready_o,
  output logic               flush_o,
  opq_data_if.buf_mp         out
);

  import opq_pkg::*;

  localparam int unsigned     PtrW    = (DataBufDepth > 1) ? $clog2(DataBufDepth) : 1;
  localparam int unsigned     CntW    = $clog2(DataBufDepth + 1);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(DataBufDepth - 1);
  localparam logic [CntW:0]   DepthW  = (CntW + 1)'(DataBufDepth);

  opq_word_u       mem_q [DataBufDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] pend_q;
  logic [CntW:0]   used;
  logic            flush_q;
  logic            push;

  // Flush register, stays low in queues without flush support
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= HasFlush && flush_i;
    end
  end

  // Words that come back during a flush are dropped
  assign push = operand_valid_i && !flush_q;

  ////////////////////////////////////////////////
  // Credits and FIFO control
  ////////////////////////////////////////////////

  // Reads issued but not yet returned
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_q) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_q + CntW'(operand_issued_i) - CntW'(operand_valid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_q) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (out.pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(out.pop);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= operand_i;
    end
  end

  // Slots taken = in flight + stored
  assign used                  = {1'b0, pend_q} + {1'b0, cnt_q};
  assign operand_queue_ready_o = used < DepthW;

  assign out.word  = mem_q[rd_ptr_q];
  assign out.valid = (cnt_q != '0) && !flush_q;
  assign out.flush = flush_q;
  assign flush_o   = flush_q;

  ////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////

  // Every returning operand matches an earlier issue
  a_no_orphan_operand: assert property (
    @(posedge clk_i) disable iff (rst_i || flush_q)
    operand_valid_i |-> (pend_q != '0)
  );

  // Requester respects the credit limit
  a_no_issue_when_full: assert property (
    @(posedge clk_i) disable iff (rst_i)
    operand_issued_i |-> operand_queue_ready_o
  );

endmodule

// File: opq_convert.sv
//////////////////////////////////////////////////
// Operand converter
// Queues commands and streams the buffered words
// to the unit, unchanged or widened per half
//////////////////////////////////////////////////

module opq_convert #(
  parameter int unsigned CmdBufDepth = opq_pkg::CmdDepth
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [1:0]                      cmd_conv_i,
  input  logic [opq_pkg::CmdLenWidth-1:0] cmd_len_i,
  input  logic                            cmd_valid_i,
  opq_data_if.conv_mp                     in,
  output logic [opq_pkg::ElenWidth-1:0]   operand_o,
  output logic                            operand_valid_o,
  input  logic                            operand_ready_i
);

  import opq_pkg::*;

  localparam int unsigned     PtrW    = (CmdBufDepth > 1) ? $clog2(CmdBufDepth) : 1;
  localparam int unsigned     CntW    = $clog2(CmdBufDepth + 1);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(CmdBufDepth - 1);
  localparam logic [CntW-1:0] FullCnt = CntW'(CmdBufDepth);

  logic [1:0]             conv_q [CmdBufDepth];
  logic [CmdLenWidth-1:0] len_q  [CmdBufDepth];
  logic [PtrW-1:0]        cmd_wr_q;
  logic [PtrW-1:0]        cmd_rd_q;
  logic [CntW-1:0]        cmd_cnt_q;
  logic                   cmd_push;
  logic                   cmd_pop;
  logic                   cmd_active;
  logic [1:0]             head_conv;
  logic [CmdLenWidth-1:0] head_len;
  logic [CmdLenWidth-1:0] out_cnt_q;
  logic                   half_q;
  logic                   widen;
  logic                   last_out;
  logic                   fire;
  logic [HalfWidth-1:0]   half_word;

  ////////////////////////////////////////////////
  // Command FIFO
  ////////////////////////////////////////////////

  assign cmd_push = cmd_valid_i && !in.flush;

  always_ff @(posedge clk_i) begin
    if (rst_i || in.flush) begin
      cmd_wr_q  <= '0;
      cmd_rd_q  <= '0;
      cmd_cnt_q <= '0;
    end else begin
      if (cmd_push) begin
        cmd_wr_q <= (cmd_wr_q == LastPtr) ? '0 : cmd_wr_q + 1'b1;
      end
      if (cmd_pop) begin
        cmd_rd_q <= (cmd_rd_q == LastPtr) ? '0 : cmd_rd_q + 1'b1;
      end
      cmd_cnt_q <= cmd_cnt_q + CntW'(cmd_push) - CntW'(cmd_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_push) begin
      conv_q[cmd_wr_q] <= cmd_conv_i;
      len_q[cmd_wr_q]  <= cmd_len_i;
    end
  end

  assign cmd_active = cmd_cnt_q != '0;
  assign head_conv  = conv_q[cmd_rd_q];
  assign head_len   = len_q[cmd_rd_q];
  assign widen      = (head_conv == ConvZext2) || (head_conv == ConvSext2);
  assign last_out   = out_cnt_q == (head_len - CmdLenWidth'(1));

  ////////////////////////////////////////////////
  // Conversion
  ////////////////////////////////////////////////

  // Low half goes out first
  assign half_word = in.word.half[half_q];

  always_comb begin
    unique case (head_conv)
      ConvZext2: operand_o = {{HalfWidth{1'b0}}, half_word};
      ConvSext2: operand_o = {{HalfWidth{half_word[HalfWidth-1]}}, half_word};
      default:   operand_o = in.word.elem;
    endcase
  end

  assign operand_valid_o = cmd_active && in.valid;
  assign fire            = operand_valid_o && operand_ready_i;
  assign cmd_pop         = fire && last_out;

  // A widened word leaves after its high half, or early at an odd tail
  assign in.pop = fire && (!widen || half_q || last_out);

  // Output count and half select of the head command
  always_ff @(posedge clk_i) begin
    if (rst_i || in.flush) begin
      out_cnt_q <= '0;
      half_q    <= 1'b0;
    end else if (fire) begin
      if (last_out) begin
        out_cnt_q <= '0;
        half_q    <= 1'b0;
      end else begin
        out_cnt_q <= out_cnt_q + CmdLenWidth'(1);
        half_q    <= widen && !half_q;
      end
    end
  end

  ////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////

  // Sequencer never overruns the command slots
  a_cmd_no_overflow: assert property (
    @(posedge clk_i) disable iff (rst_i)
    cmd_valid_i |-> (cmd_cnt_q != FullCnt)
  );

  // The buffer head is present and not being flushed on a pop
  a_pop_needs_word: assert property (
    @(posedge clk_i) disable iff (rst_i)
    in.pop |-> (in.valid && !in.flush)
  );

endmodule

// File: opq_perm_arbiter.sv
//////////////////////////////////////////////////
// Permutation stream arbiter
// Merges index and value queues onto one output,
// index queue first
//////////////////////////////////////////////////

module opq_perm_arbiter (
  input  logic [opq_pkg::ElenWidth-1:0] idx_operand_i,
  input  logic                          idx_valid_i,
  output logic                          idx_ready_o,
  input  logic [opq_pkg::ElenWidth-1:0] val_operand_i,
  input  logic                          val_valid_i,
  output logic                          val_ready_o,
  output logic [opq_pkg::ElenWidth-1:0] permu_operand_o,
  output logic                          permu_sel_idx_val_o,
  output logic                          permu_operand_valid_o,
  input  logic [1:0]                    permu_operand_ready_i
);

  logic gnt_idx;
  logic gnt_val;

  // Fixed priority
  assign gnt_idx = idx_valid_i;
  assign gnt_val = val_valid_i && !idx_valid_i;

  assign permu_operand_o       = gnt_idx ? idx_operand_i : val_operand_i;
  assign permu_sel_idx_val_o   = !gnt_idx;
  assign permu_operand_valid_o = gnt_idx || gnt_val;

  // Each queue listens only to its own ready bit
  assign idx_ready_o = permu_operand_ready_i[0] && gnt_idx;
  assign val_ready_o = permu_operand_ready_i[1] && gnt_val;

endmodule

// File: opq_stage.sv
//////////////////////////////////////////////////
// Operand queue stage
// Five operand queues of one lane between the
// register file and the ALU, store and perm units
//////////////////////////////////////////////////

module opq_stage #(
  parameter int unsigned ValuDepth   = opq_pkg::ValuDataDepth,
  parameter int unsigned StuDepth    = opq_pkg::StuDataDepth,
  parameter int unsigned PermDepth   = opq_pkg::PermDataDepth,
  parameter int unsigned CmdBufDepth = opq_pkg::CmdDepth
) (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  // Register file and operand requester
  input  opq_pkg::opq_word_u [opq_pkg::NrQueues-1:0]          operand_i,
  input  logic [opq_pkg::NrQueues-1:0]                        operand_valid_i,
  input  logic [opq_pkg::NrQueues-1:0]                        operand_issued_i,
  output logic [opq_pkg::NrQueues-1:0]                        operand_queue_ready_o,
  // Commands
  input  logic [opq_pkg::NrQueues-1:0][1:0]                   cmd_conv_i,
  input  logic [opq_pkg::NrQueues-1:0][opq_pkg::CmdLenWidth-1:0] cmd_len_i,
  input  logic [opq_pkg::NrQueues-1:0]                        cmd_valid_i,
  // Store exception flush
  input  logic                                                lsu_ex_flush_i,
  output logic                                                lsu_ex_flush_o,
  // ALU
  output logic [1:0][opq_pkg::ElenWidth-1:0]                  alu_operand_o,
  output logic [1:0]                                          alu_operand_valid_o,
  input  logic [1:0]                                          alu_operand_ready_i,
  // Store unit
  output logic [opq_pkg::ElenWidth-1:0]                       stu_operand_o,
  output logic                                                stu_operand_valid_o,
  input  logic                                                stu_operand_ready_i,
  // Permutation unit
  output logic [opq_pkg::ElenWidth-1:0]                       permu_operand_o,
  output logic                                                permu_sel_idx_val_o,
  output logic                                                permu_operand_valid_o,
  input  logic [1:0]                                          permu_operand_ready_i
);

  import opq_pkg::*;

  logic [NrQueues-1:0][ElenWidth-1:0] q_operand;
  logic [NrQueues-1:0]                q_valid;
  logic [NrQueues-1:0]                q_ready;
  logic [NrQueues-1:0]                q_flush;

  ////////////////////////////////////////////////
  // Queues
  ////////////////////////////////////////////////

  for (genvar q = 0; q < NrQueues; q++) begin : gen_queue
    // Store queue is the only flushable one
    localparam bit          IsStore = (q == StA);
    localparam int unsigned Depth   = IsStore ? StuDepth :
                                      ((q == PermIdx) || (q == PermVal)) ? PermDepth :
                                      ValuDepth;

    opq_data_if data_if ();

    opq_buffer #(
      .DataBufDepth(Depth  ),
      .HasFlush    (IsStore)
    ) i_buffer (
      .clk_i                (clk_i                           ),
      .rst_i                (rst_i                           ),
      .flush_i              (IsStore ? lsu_ex_flush_i : 1'b0 ),
      .operand_i            (operand_i[q]                    ),
      .operand_valid_i      (operand_valid_i[q]              ),
      .operand_issued_i     (operand_issued_i[q]             ),
      .operand_queue_ready_o(operand_queue_ready_o[q]        ),
      .flush_o              (q_flush[q]                      ),
      .out                  (data_if                         )
    );

    opq_convert #(
      .CmdBufDepth(CmdBufDepth)
    ) i_convert (
      .clk_i          (clk_i         ),
      .rst_i          (rst_i         ),
      .cmd_conv_i     (cmd_conv_i[q] ),
      .cmd_len_i      (cmd_len_i[q]  ),
      .cmd_valid_i    (cmd_valid_i[q]),
      .in             (data_if       ),
      .operand_o      (q_operand[q]  ),
      .operand_valid_o(q_valid[q]    ),
      .operand_ready_i(q_ready[q]    )
    );
  end

  // Registered flush goes back out
  assign lsu_ex_flush_o = q_flush[StA];

  // ALU and store unit
  assign alu_operand_o[0]       = q_operand[AluA];
  assign alu_operand_o[1]       = q_operand[AluB];
  assign alu_operand_valid_o[0] = q_valid[AluA];
  assign alu_operand_valid_o[1] = q_valid[AluB];
  assign q_ready[AluA]          = alu_operand_ready_i[0];
  assign q_ready[AluB]          = alu_operand_ready_i[1];

  assign stu_operand_o       = q_operand[StA];
  assign stu_operand_valid_o = q_valid[StA];
  assign q_ready[StA]        = stu_operand_ready_i;

  ////////////////////////////////////////////////
  // Permutation output
  ////////////////////////////////////////////////

  opq_perm_arbiter i_perm_arbiter (
    .idx_operand_i        (q_operand[PermIdx]   ),
    .idx_valid_i          (q_valid[PermIdx]     ),
    .idx_ready_o          (q_ready[PermIdx]     ),
    .val_operand_i        (q_operand[PermVal]   ),
    .val_valid_i          (q_valid[PermVal]     ),
    .val_ready_o          (q_ready[PermVal]     ),
    .permu_operand_o      (permu_operand_o      ),
    .permu_sel_idx_val_o  (permu_sel_idx_val_o  ),
    .permu_operand_valid_o(permu_operand_valid_o),
    .permu_operand_ready_i(permu_operand_ready_i)
  );

endmodule

// File: opq_checker.sv
//////////////////////////////////////////////////
// Operand queue checker
// Models every queue from the observed operands and
// commands and compares the DUT outputs each cycle
//////////////////////////////////////////////////

module opq_checker #(
  parameter int unsigned ValuDepth = 5,
  parameter int unsigned StuDepth  = 2,
  parameter int unsigned PermDepth = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [4:0][63:0]          operand_i,
  input  logic [4:0]                operand_valid_i,
  input  logic [4:0]                operand_issued_i,
  input  logic [4:0]                operand_queue_ready_o,
  input  logic [4:0][1:0]           cmd_conv_i,
  input  logic [4:0][7:0]           cmd_len_i,
  input  logic [4:0]                cmd_valid_i,
  input  logic                      lsu_ex_flush_i,
  input  logic                      lsu_ex_flush_o,
  input  logic [1:0][63:0]          alu_operand_o,
  input  logic [1:0]                alu_operand_valid_o,
  input  logic [1:0]                alu_operand_ready_i,
  input  logic [63:0]               stu_operand_o,
  input  logic                      stu_operand_valid_o,
  input  logic                      stu_operand_ready_i,
  input  logic [63:0]               permu_operand_o,
  input  logic                      permu_sel_idx_val_o,
  input  logic                      permu_operand_valid_o,
  input  logic [1:0]                permu_operand_ready_i,
  input  int                        test_id_i,
  input  logic                      test_done_i,
  output int                        err_cnt_o,
  output int                        done_cnt_o [5]
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [63:0] words [5][$];
  logic [1:0]  convs [5][$];
  int          lens  [5][$];
  int          out_cnt [5];
  bit          half_sel [5];
  int          pend [5];
  bit          flush_d;
  int          test_errs;

  // Expected unit word for one half or the whole element
  function automatic logic [63:0] expect_word(logic [63:0] w, logic [1:0] conv, bit hi);
    logic [31:0] h;
    h = hi ? w[63:32] : w[31:0];
    if (conv == 2'd1) return {32'h0, h};
    if (conv == 2'd2) return {{32{h[31]}}, h};
    return w;
  endfunction

  function automatic bit model_valid(int q);
    return convs[q].size() > 0 && words[q].size() > 0 && !(q == 2 && lsu_ex_flush_o);
  endfunction

  function automatic logic [63:0] model_word(int q);
    return expect_word(words[q][0], convs[q][0], half_sel[q]);
  endfunction

  function automatic int depth_of(int q);
    if (q == 2) return StuDepth;
    if (q >= 3) return PermDepth;
    return ValuDepth;
  endfunction

  task automatic compare(string name, logic [63:0] exp, logic [63:0] got);
    if (exp !== got) begin
      $display("[FAIL] t=%0t %s exp=%h got=%h", $time, name, exp, got);
      err_cnt_o++;
      test_errs++;
    end
  endtask

  // Consume one output of queue q
  task automatic advance(int q);
    bit widen;
    bit last;
    widen = (convs[q][0] == 2'd1) || (convs[q][0] == 2'd2);
    last  = out_cnt[q] == lens[q][0] - 1;
    if (!widen || half_sel[q] || last) void'(words[q].pop_front());
    if (last) begin
      void'(convs[q].pop_front());
      void'(lens[q].pop_front());
      out_cnt[q]  = 0;
      half_sel[q] = 0;
    end else begin
      out_cnt[q]++;
      half_sel[q] = widen && !half_sel[q];
    end
    done_cnt_o[q]++;
  endtask

  task automatic clear_queue(int q);
    words[q].delete();
    convs[q].delete();
    lens[q].delete();
    out_cnt[q]  = 0;
    half_sel[q] = 0;
    pend[q]     = 0;
  endtask

  initial begin
    err_cnt_o = 0;
    test_errs = 0;
    for (int q = 0; q < 5; q++) done_cnt_o[q] = 0;
  end

  always @(posedge clk_i) begin
    bit fire [5];
    bit ev [5];
    bit flush_now;
    if (rst_i) begin
      for (int q = 0; q < 5; q++) clear_queue(q);
      flush_d = 0;
    end else begin
      flush_now = lsu_ex_flush_o;
      for (int q = 0; q < 5; q++) begin
        ev[q]   = model_valid(q);
        fire[q] = 0;
        compare($sformatf("operand_queue_ready_o[%0d]", q),
                64'(pend[q] + words[q].size() < depth_of(q)), 64'(operand_queue_ready_o[q]));
      end
      compare("lsu_ex_flush_o", 64'(flush_d), 64'(flush_now));
      for (int a = 0; a < 2; a++) begin
        compare($sformatf("alu_operand_valid_o[%0d]", a), 64'(ev[a]),
                64'(alu_operand_valid_o[a]));
        if (ev[a] && alu_operand_valid_o[a]) begin
          compare($sformatf("alu_operand_o[%0d]", a), model_word(a), alu_operand_o[a]);
          fire[a] = alu_operand_ready_i[a];
        end
      end
      compare("stu_operand_valid_o", 64'(ev[2]), 64'(stu_operand_valid_o));
      if (ev[2] && stu_operand_valid_o) begin
        compare("stu_operand_o", model_word(2), stu_operand_o);
        fire[2] = stu_operand_ready_i;
      end
      // Index queue has priority on the shared output
      compare("permu_operand_valid_o", 64'(ev[3] || ev[4]), 64'(permu_operand_valid_o));
      if ((ev[3] || ev[4]) && permu_operand_valid_o) begin
        compare("permu_sel_idx_val_o", 64'(!ev[3]), 64'(permu_sel_idx_val_o));
        compare("permu_operand_o", model_word(ev[3] ? 3 : 4), permu_operand_o);
        if (ev[3]) fire[3] = permu_operand_ready_i[0];
        else fire[4] = permu_operand_ready_i[1];
      end
      for (int q = 0; q < 5; q++) if (fire[q]) advance(q);
      if (flush_now) clear_queue(2);
      for (int q = 0; q < 5; q++) begin
        if (!(q == 2 && flush_now)) begin
          pend[q] = pend[q] + int'(operand_issued_i[q]) - int'(operand_valid_i[q]);
          if (operand_valid_i[q]) words[q].push_back(operand_i[q]);
          if (cmd_valid_i[q]) begin
            convs[q].push_back(cmd_conv_i[q]);
            lens[q].push_back(int'(cmd_len_i[q]));
          end
        end
      end
      flush_d = lsu_ex_flush_i;
    end
    if (test_done_i) begin
      $display("test %0d finished with %0d errors", test_id_i, test_errs);
      test_errs = 0;
    end
  end

endmodule

// File: tb_opq_stage.sv
//////////////////////////////////////////////////
// Operand queue stage testbench
// Table driven stimulus for all five queues
//////////////////////////////////////////////////

module tb_opq_stage;

  timeunit 1ns;
  timeprecision 100ps;

  import opq_pkg::*;

  localparam int NrRows  = 6;
  localparam int Timeout = 400;

  typedef struct {
    int         q;
    logic [1:0] conv;
    int         nwords;
    logic [63:0] base;
    bit         rnd_ready;
    bit         flush;
  } row_t;

  logic clk_i;
  logic rst_i;
  opq_word_u [NrQueues-1:0]                operand_i;
  logic [NrQueues-1:0]                     operand_valid_i;
  logic [NrQueues-1:0]                     operand_issued_i;
  logic [NrQueues-1:0]                     operand_queue_ready_o;
  logic [NrQueues-1:0][1:0]                cmd_conv_i;
  logic [NrQueues-1:0][CmdLenWidth-1:0]    cmd_len_i;
  logic [NrQueues-1:0]                     cmd_valid_i;
  logic lsu_ex_flush_i, lsu_ex_flush_o;
  logic [1:0][ElenWidth-1:0] alu_operand_o;
  logic [1:0] alu_operand_valid_o, alu_operand_ready_i;
  logic [ElenWidth-1:0] stu_operand_o, permu_operand_o;
  logic stu_operand_valid_o, stu_operand_ready_i;
  logic permu_sel_idx_val_o, permu_operand_valid_o;
  logic [1:0] permu_operand_ready_i;
  int   test_id;
  logic test_done;
  int   err_cnt;
  int   done_cnt [5];
  bit   timed_out;
  row_t rows [NrRows];

  opq_stage dut_i (.*);

  opq_checker #(
    .ValuDepth(ValuDataDepth), .StuDepth(StuDataDepth), .PermDepth(PermDataDepth)
  ) i_checker (
    .operand_i(operand_i), .test_id_i(test_id), .test_done_i(test_done),
    .err_cnt_o(err_cnt), .done_cnt_o(done_cnt), .*
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Unit side ready for the queue under test
  task automatic set_unit_ready(int q, logic [1:0] r);
    if (q <= AluB) alu_operand_ready_i[q] = r[0];
    else if (q == StA) stu_operand_ready_i = r[0];
    else permu_operand_ready_i = r;
  endtask

  // Issue a read, then return its word a cycle later
  task automatic feed(int q, bit pair, int n, logic [63:0] base);
    int cnt;
    for (int i = 0; i < n && !timed_out; i++) begin
      cnt = 0;
      while (!(operand_queue_ready_o[q] && (!pair || operand_queue_ready_o[PermVal]))) begin
        @(negedge clk_i);
        cnt++;
        if (cnt > Timeout) begin
          $display("timeout: queue %0d never offered a credit", q);
          timed_out = 1;
          return;
        end
      end
      operand_issued_i[q] = 1'b1;
      if (pair) operand_issued_i[PermVal] = 1'b1;
      @(negedge clk_i);
      operand_issued_i = '0;
      operand_valid_i[q] = 1'b1;
      operand_i[q].elem  = base ^ {$urandom(), $urandom()};
      if (pair) begin
        operand_valid_i[PermVal] = 1'b1;
        operand_i[PermVal].elem  = ~base ^ {$urandom(), $urandom()};
      end
      @(negedge clk_i);
      operand_valid_i = '0;
    end
  endtask

  // Toggle unit ready until all expected words have left
  task automatic drive_ready(int q, bit pair, bit rnd, int target, int target_val);
    int cnt;
    cnt = 0;
    while (done_cnt[q] < target || (pair && done_cnt[PermVal] < target_val)) begin
      if (rnd) set_unit_ready(q, (cnt < 8) ? 2'b00 : 2'($urandom()));
      else set_unit_ready(q, 2'b11);
      @(negedge clk_i);
      cnt++;
      if (cnt > Timeout || timed_out) begin
        $display("timeout: queue %0d delivered %0d of %0d words", q, done_cnt[q], target);
        timed_out = 1;
        break;
      end
    end
    set_unit_ready(q, 2'b00);
  endtask

  task automatic send_cmd(int q, logic [1:0] conv, int len);
    cmd_valid_i[q] = 1'b1;
    cmd_conv_i[q]  = conv;
    cmd_len_i[q]   = CmdLenWidth'(len);
  endtask

  task automatic run_row(row_t r);
    bit pair;
    int nout;
    int t0;
    int t1;
    pair = r.q == PermIdx;
    nout = (r.conv == ConvNone) ? r.nwords : 2 * r.nwords;
    if (r.flush) begin
      // Stale words and command, wiped by the flush
      send_cmd(StA, ConvNone, 2);
      @(negedge clk_i);
      cmd_valid_i = '0;
      feed(StA, 0, 2, 64'hdead_0000_beef_0000);
      lsu_ex_flush_i = 1'b1;
      @(negedge clk_i);
      lsu_ex_flush_i = 1'b0;
      repeat (3) @(negedge clk_i);
    end
    t0 = done_cnt[r.q] + nout;
    t1 = done_cnt[PermVal] + nout;
    send_cmd(r.q, r.conv, nout);
    if (pair) send_cmd(PermVal, r.conv, nout);
    @(negedge clk_i);
    cmd_valid_i = '0;
    fork
      feed(r.q, pair, r.nwords, r.base);
      drive_ready(r.q, pair, r.rnd_ready, t0, t1);
    join
  endtask

  initial begin
    void'($urandom(32'hea59bc9b));
    rows[0] = '{AluA,    ConvNone,  4, 64'h0123_4567_89ab_cdef, 0, 0};
    rows[1] = '{AluB,    ConvSext2, 3, 64'h8000_0000_8000_0000, 0, 0};
    rows[2] = '{StA,     ConvZext2, 5, 64'hffff_0000_ffff_0000, 1, 0};
    rows[3] = '{StA,     ConvNone,  3, 64'h5a5a_5a5a_a5a5_a5a5, 0, 1};
    rows[4] = '{PermIdx, ConvNone,  3, 64'h0000_0001_0000_0002, 1, 0};
    rows[5] = '{AluA,    ConvSext2, 2, 64'h7fff_ffff_8000_0001, 1, 0};
    rst_i = 1'b1;
    operand_i = '0;
    operand_valid_i = '0;
    operand_issued_i = '0;
    cmd_conv_i = '0;
    cmd_len_i = '0;
    cmd_valid_i = '0;
    lsu_ex_flush_i = 1'b0;
    alu_operand_ready_i = '0;
    stu_operand_ready_i = 1'b0;
    permu_operand_ready_i = '0;
    test_id = 0;
    test_done = 1'b0;
    timed_out = 0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    repeat (2) @(negedge clk_i);
    for (int i = 0; i < NrRows && !timed_out; i++) begin
      test_id = i;
      run_row(rows[i]);
      test_done = 1'b1;
      @(negedge clk_i);
      test_done = 1'b0;
    end
    repeat (4) @(negedge clk_i);
    $display("tests run: %0d, errors: %0d, timeout: %0d", NrRows, err_cnt, timed_out);
    if (timed_out || err_cnt != 0) begin
      $display("=== FAIL ===");
    end else begin
      $display("=== PASS ===");
    end
    $finish;
  end

endmodule

// File: opq_stage.f
opq_pkg.sv
opq_data_if.sv
opq_buffer.sv
opq_convert.sv
opq_perm_arbiter.sv
opq_stage.sv
opq_checker.sv
tb_opq_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_opq_stage
FLIST     ?= opq_stage.f
LOG       ?= sim.log

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
